/* sim.f */
+incdir+include
src/keyboard_pkg.sv
src/ps2Receiver.sv
src/scanCodeMap.sv
src/keyControl.sv
src/keyMatrix.sv
src/keyboard.sv
tests/keyboardTb.sv

/* run.sh */
#!/bin/sh

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal --top-module keyboardTb \
	-f sim.f --Mdir build -o keyboardSim
status=$?
if [ $status -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit 1
fi

./build/keyboardSim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "RESULT: FAIL" sim.log; then
	exit 1
fi

if ! grep -q "RESULT: PASS" sim.log; then
	echo "simulation log holds no result line"
	exit 1
fi

exit 0

/* tests/keyboardTb.sv */
`timescale 1ns/100ps
`default_nettype none
`include "keyboard_macros.svh"

module keyboardTb;

	localparam int RandomEvents = 40;
	localparam int MaxFrames = 2 * RandomEvents + 20;
	localparam longint WatchdogNs = 2 * MaxFrames * 11 * 16 * 20; // 11 bits, 16 ticks, 20 ns

	logic CLK;
	logic CLK_en;
	logic nRESET;
	logic autoscan;
	keyboard_pkg::column_t column;
	keyboard_pkg::row_t row;
	logic ps2Clk;
	logic ps2Data;
	logic columnMatch;
	logic rowMatch;
	logic nBreak;

	logic [15:0] lfsr;
	keyboard_pkg::rowBits_t model [16];
	logic modelPending;
	keyboard_pkg::column_t autoColumn;
	keyboard_pkg::scanCode_t scanTable [16];
	keyboard_pkg::keyCode_t codeTable [16];
	logic validTable [16];
	int errorCount;
	int checkCount;
	int testCount;
	int failedTests;
	int testStartErrors;

	keyboard u_keyboard (
		.CLK         (CLK),
		.CLK_en      (CLK_en),
		.nRESET      (nRESET),
		.autoscan    (autoscan),
		.column      (column),
		.row         (row),
		.ps2Clk      (ps2Clk),
		.ps2Data     (ps2Data),
		.columnMatch (columnMatch),
		.rowMatch    (rowMatch),
		.nBreak      (nBreak)
	);

	always #5 CLK = ~CLK;

	always @(posedge CLK) begin
		CLK_en <= ~CLK_en; // one tick every second cycle
	end

	// expected autoscan column, ticks since reset
	always @(posedge CLK) begin
		if (!nRESET)
			autoColumn <= '0;
		else if (CLK_en)
			autoColumn <= autoColumn + 4'd1;
	end

	initial begin
		#(WatchdogNs);
		$display("watchdog expired after %0d ns, tests did not complete", WatchdogNs);
		$display("RESULT: FAIL");
		$finish;
	end

	// x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] randBits(input int n);
		logic [15:0] value;
		logic feedback;
		value = '0;
		for (int i = 0; i < n; i++) begin
			feedback = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
			lfsr = {lfsr[14:0], feedback};
			value = {value[14:0], feedback};
		end
		return value;
	endfunction

	function automatic logic colOr(input int c);
		return |model[c][7:1]; // row 0 never counts
	endfunction

	task automatic setEntry(input int idx, input logic [7:0] scan, input logic [6:0] code,
			input logic valid);
		scanTable[idx] = scan;
		codeTable[idx] = code;
		validTable[idx] = valid;
	endtask

	task automatic fillTables();
		setEntry(0, 8'h1C, 7'h41, 1'b1);  // a
		setEntry(1, 8'h1B, 7'h51, 1'b1);  // s
		setEntry(2, 8'h16, 7'h30, 1'b1);  // 1
		setEntry(3, 8'h12, 7'h00, 1'b1);  // left shift, row 0
		setEntry(4, 8'h29, 7'h62, 1'b1);  // space
		setEntry(5, 8'h5A, 7'h49, 1'b1);  // return
		setEntry(6, 8'h75, 7'h39, 1'b1);  // up
		setEntry(7, 8'h05, 7'h71, 1'b1);  // f1
		setEntry(8, 8'h0D, 7'h60, 1'b1);  // tab
		setEntry(9, 8'h3A, 7'h65, 1'b1);  // m
		setEntry(10, 8'h4A, 7'h68, 1'b1); // slash
		setEntry(11, 8'h14, 7'h01, 1'b1); // ctrl, row 0
		setEntry(12, 8'h66, 7'h59, 1'b1); // delete
		setEntry(13, 8'h78, 7'h7E, 1'b1); // BREAK
		setEntry(14, 8'h5F, 7'h00, 1'b0); // unmapped
		setEntry(15, 8'h68, 7'h00, 1'b0); // unmapped
	endtask

	task automatic waitTicks(input int n);
		repeat (n) begin
			@(posedge CLK);
			while (!CLK_en)
				@(posedge CLK);
		end
	endtask

	task automatic checkValue(input string name, input logic [7:0] expected,
			input logic [7:0] actual);
		checkCount++;
		assert (actual === expected) else begin
			$display("CHECK FAILED %s expected %0h got %0h", name, expected, actual);
			errorCount++;
		end
	endtask

	// press/release rule applied to the model
	task automatic modelApply(input keyboard_pkg::scanCode_t b);
		if (b == `KB_RELEASE_CODE) begin
			modelPending = 1'b1;
		end else begin
			for (int i = 0; i < 16; i++) begin
				if (scanTable[i] == b && validTable[i]) begin
					model[codeTable[i][3:0]][codeTable[i][6:4]] = ~modelPending;
					modelPending = 1'b0;
				end
			end
		end
	endtask

	// start, 8 data LSB first, parity, stop
	task automatic sendFrame(input keyboard_pkg::scanCode_t data, input logic badParity,
			input int bitCount);
		logic [10:0] frame;
		logic parity;
		parity = ~^data;
		if (badParity)
			parity = ~parity;
		frame = {1'b1, parity, data, 1'b0};
		for (int i = 0; i < bitCount; i++) begin
			ps2Data <= frame[i];
			waitTicks(8);
			ps2Clk <= 1'b0;
			waitTicks(8);
			ps2Clk <= 1'b1;
		end
		ps2Data <= 1'b1; // back to idle
	endtask

	task automatic scanCheck();
		for (int c = 0; c < 16; c++) begin
			for (int r = 0; r < 8; r++) begin
				column <= keyboard_pkg::column_t'(c);
				row <= keyboard_pkg::row_t'(r);
				@(posedge CLK);
				checkValue($sformatf("rowMatch[%0h][%0h]", c, r), model[c][r], rowMatch);
				checkValue($sformatf("columnMatch[%0h]", c), colOr(c), columnMatch);
			end
		end
		checkValue("nBreak", {7'h0, ~model[`KB_BREAK_COLUMN][`KB_BREAK_ROW]}, nBreak);
	endtask

	task automatic sendByte(input keyboard_pkg::scanCode_t b);
		sendFrame(b, 1'b0, 11);
		modelApply(b);
		scanCheck();
	endtask

	task automatic finishTest(input string name);
		testCount++;
		if (errorCount == testStartErrors) begin
			$display("test %0d %s: ok", testCount, name);
		end else begin
			failedTests++;
			$display("test %0d %s: %0d errors", testCount, name, errorCount - testStartErrors);
		end
		testStartErrors = errorCount;
	endtask

	initial begin
		int idx;
		logic releaseFirst;
		CLK = 1'b0;
		CLK_en = 1'b0;
		nRESET = 1'b0;
		autoscan = 1'b0;
		column = '0;
		row = '0;
		ps2Clk = 1'b1;
		ps2Data = 1'b1;
		lfsr = 16'd23167;
		modelPending = 1'b0;
		errorCount = 0;
		checkCount = 0;
		testCount = 0;
		failedTests = 0;
		testStartErrors = 0;
		for (int c = 0; c < 16; c++)
			model[c] = '0;
		fillTables();
		repeat (3) @(posedge CLK);
		nRESET <= 1'b1;
		@(posedge CLK);

		scanCheck();
		finishTest("reset state");

		for (int ev = 0; ev < RandomEvents; ev++) begin
			idx = int'(randBits(4));
			releaseFirst = (randBits(1) != 16'd0);
			if (releaseFirst)
				sendByte(`KB_RELEASE_CODE);
			sendByte(scanTable[idx]);
		end
		finishTest("random press and release");

		sendByte(8'h1C); // clears any release left pending
		sendByte(8'h1C);
		sendByte(8'hE0);
		sendByte(8'h5F);
		sendByte(`KB_RELEASE_CODE);
		sendByte(8'h68); // release stays pending
		sendByte(8'h1C);
		finishTest("ignored codes");

		sendByte(`KB_RELEASE_CODE);
		sendByte(8'h29); // space up, so a wrongly taken press would show
		sendFrame(8'h29, 1'b1, 11);
		scanCheck();
		sendFrame(8'h29, 1'b0, 4); // cut short
		waitTicks(`KB_RX_TIMEOUT + 16);
		scanCheck();
		sendByte(8'h29);
		finishTest("bad frames");

		sendByte(8'h78);
		checkValue("nBreak", 8'h0, nBreak);
		sendByte(`KB_RELEASE_CODE);
		sendByte(8'h78);
		checkValue("nBreak", 8'h1, nBreak);
		finishTest("break key");

		sendByte(8'h1C);
		sendByte(8'h75);
		autoscan <= 1'b1;
		row <= keyboard_pkg::row_t'(4); // row of the a key
		repeat (64) begin
			@(posedge CLK);
			checkValue($sformatf("columnMatch[%0h]", autoColumn), colOr(autoColumn),
				columnMatch);
			checkValue("rowMatch", 8'h0, rowMatch);
		end
		autoscan <= 1'b0;
		@(posedge CLK);
		finishTest("autoscan");

		$display("tests: %0d, failed: %0d, checks: %0d, errors: %0d",
			testCount, failedTests, checkCount, errorCount);
		if (errorCount == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

/* src/keyboard.sv */
`timescale 1ns/100ps
`default_nettype none

module keyboard (
	input  wire                        CLK,
	input  wire                        CLK_en,
	input  wire                        nRESET,
	input  wire                        autoscan,
	input  wire keyboard_pkg::column_t column,
	input  wire keyboard_pkg::row_t    row,
	input  wire                        ps2Clk,
	input  wire                        ps2Data,
	output logic                       columnMatch,
	output logic                       rowMatch,
	output logic                       nBreak
);

	keyboard_pkg::scanCode_t rxByte;
	logic rxDone;
	keyboard_pkg::keyCode_t keyCode;
	logic keyValid;
	logic wrEn;
	logic wrSet;
	keyboard_pkg::keyCode_t wrCode;
	keyboard_pkg::column_t scanColumn;

	ps2Receiver u_ps2Receiver (
		.CLK     (CLK),
		.CLK_en  (CLK_en),
		.nRESET  (nRESET),
		.ps2Clk  (ps2Clk),
		.ps2Data (ps2Data),
		.rxByte  (rxByte),
		.rxDone  (rxDone)
	);

	scanCodeMap u_scanCodeMap (
		.rxByte   (rxByte),
		.keyCode  (keyCode),
		.keyValid (keyValid)
	);

	keyControl u_keyControl (
		.CLK        (CLK),
		.CLK_en     (CLK_en),
		.nRESET     (nRESET),
		.autoscan   (autoscan),
		.column     (column),
		.rxByte     (rxByte),
		.rxDone     (rxDone),
		.keyCode    (keyCode),
		.keyValid   (keyValid),
		.wrEn       (wrEn),
		.wrSet      (wrSet),
		.wrCode     (wrCode),
		.scanColumn (scanColumn)
	);

	keyMatrix u_keyMatrix (
		.CLK         (CLK),
		.nRESET      (nRESET),
		.wrEn        (wrEn),
		.wrSet       (wrSet),
		.wrCode      (wrCode),
		.scanColumn  (scanColumn),
		.row         (row),
		.autoscan    (autoscan),
		.columnMatch (columnMatch),
		.rowMatch    (rowMatch),
		.nBreak      (nBreak)
	);

endmodule

`default_nettype wire

/* src/keyMatrix.sv */
`timescale 1ns/100ps
`default_nettype none
`include "keyboard_macros.svh"

module keyMatrix (
	input  wire                         CLK,
	input  wire                         nRESET,
	input  wire                         wrEn,
	input  wire                         wrSet,
	input  wire keyboard_pkg::keyCode_t wrCode,
	input  wire keyboard_pkg::column_t  scanColumn,
	input  wire keyboard_pkg::row_t     row,
	input  wire                         autoscan,
	output logic                        columnMatch,
	output logic                        rowMatch,
	output logic                        nBreak
);

	keyboard_pkg::rowBits_t keys [`KB_COLUMNS];
	keyboard_pkg::column_t wrColumn;
	keyboard_pkg::row_t wrRow;
	keyboard_pkg::rowBits_t scanBits;
	keyboard_pkg::rowBits_t breakBits;

	assign wrColumn = wrCode[3:0];
	assign wrRow = wrCode[6:4];

	// one key bit per write, neighbours untouched
	always_ff @(posedge CLK) begin
		if (!nRESET) begin
			for (int c = 0; c < `KB_COLUMNS; c++)
				keys[c] <= '0;
		end else if (wrEn) begin
			keys[wrColumn][wrRow] <= wrSet;
		end
	end

	assign scanBits = keys[scanColumn];

	// row 0 holds the modifier keys and is left out
	assign columnMatch = |scanBits[7:1];

	// no per-key read while autoscanning
	assign rowMatch = autoscan ? 1'b0 : scanBits[row];

	assign breakBits = keys[`KB_BREAK_COLUMN];
	assign nBreak = ~breakBits[`KB_BREAK_ROW]; // active low

endmodule

`default_nettype wire

/* src/keyControl.sv */
`timescale 1ns/100ps
`default_nettype none
`include "keyboard_macros.svh"

module keyControl (
	input  wire                          CLK,
	input  wire                          CLK_en,
	input  wire                          nRESET,
	input  wire                          autoscan,
	input  wire keyboard_pkg::column_t   column,
	input  wire keyboard_pkg::scanCode_t rxByte,
	input  wire                          rxDone,
	input  wire keyboard_pkg::keyCode_t  keyCode,
	input  wire                          keyValid,
	output logic                         wrEn,
	output logic                         wrSet,
	output keyboard_pkg::keyCode_t       wrCode,
	output keyboard_pkg::column_t        scanColumn
);

	logic releasePending;
	logic isRelease;
	keyboard_pkg::column_t colCount;

	assign isRelease = (rxByte == `KB_RELEASE_CODE);

	// release prefix stays pending across unmapped bytes
	always_ff @(posedge CLK) begin
		if (!nRESET) begin
			releasePending <= 1'b0;
		end else if (rxDone) begin
			if (isRelease)
				releasePending <= 1'b1;
			else if (keyValid)
				releasePending <= 1'b0; // consumed by this key
		end
	end

	assign wrEn = rxDone & keyValid & ~isRelease;
	assign wrSet = ~releasePending;
	assign wrCode = keyCode;

	// free-running autoscan column
	always_ff @(posedge CLK) begin
		if (!nRESET)
			colCount <= '0;
		else if (CLK_en) begin
			if (colCount == keyboard_pkg::column_t'(`KB_COLUMNS - 1))
				colCount <= '0;
			else
				colCount <= colCount + 1'b1;
		end
	end

	assign scanColumn = autoscan ? colCount : column;

endmodule

`default_nettype wire

/* src/scanCodeMap.sv */
`timescale 1ns/100ps
`default_nettype none

module scanCodeMap (
	input  wire keyboard_pkg::scanCode_t rxByte,
	output keyboard_pkg::keyCode_t       keyCode,
	output logic                         keyValid
);

	always_comb begin
		keyCode = '0;
		keyValid = 1'b1;
		case (rxByte)
			8'h76: keyCode = 7'h70; // escape
			8'h0E: keyCode = 7'h47; // backtick as @
			8'h16: keyCode = 7'h30; // 1
			8'h1E: keyCode = 7'h31; // 2
			8'h26: keyCode = 7'h11; // 3
			8'h25: keyCode = 7'h12; // 4
			8'h2E: keyCode = 7'h13; // 5
			8'h36: keyCode = 7'h34; // 6
			8'h3D: keyCode = 7'h24; // 7
			8'h3E: keyCode = 7'h15; // 8
			8'h46: keyCode = 7'h26; // 9
			8'h45: keyCode = 7'h27; // 0
			8'h4E: keyCode = 7'h17; // minus
			8'h55: keyCode = 7'h18; // equals as caret
			8'h66: keyCode = 7'h59; // backspace as delete
			8'h0D: keyCode = 7'h60; // tab
			8'h15: keyCode = 7'h10; // q
			8'h1D: keyCode = 7'h21; // w
			8'h24: keyCode = 7'h22; // e
			8'h2D: keyCode = 7'h33; // r
			8'h2C: keyCode = 7'h23; // t
			8'h35: keyCode = 7'h44; // y
			8'h3C: keyCode = 7'h35; // u
			8'h43: keyCode = 7'h25; // i
			8'h44: keyCode = 7'h36; // o
			8'h4D: keyCode = 7'h37; // p
			8'h54: keyCode = 7'h38; // open bracket
			8'h5B: keyCode = 7'h58; // close bracket
			8'h5A: keyCode = 7'h49; // return
			8'h14: keyCode = 7'h01; // left ctrl
			8'h1C: keyCode = 7'h41; // a
			8'h1B: keyCode = 7'h51; // s
			8'h23: keyCode = 7'h32; // d
			8'h2B: keyCode = 7'h43; // f
			8'h34: keyCode = 7'h53; // g
			8'h33: keyCode = 7'h54; // h
			8'h3B: keyCode = 7'h45; // j
			8'h42: keyCode = 7'h46; // k
			8'h4B: keyCode = 7'h56; // l
			8'h4C: keyCode = 7'h57; // semicolon
			8'h52: keyCode = 7'h48; // quote as colon
			8'h5D: keyCode = 7'h28; // hash as underscore
			8'h12: keyCode = 7'h00; // left shift
			8'h61: keyCode = 7'h78; // backslash, UK layout
			8'h1A: keyCode = 7'h61; // z
			8'h22: keyCode = 7'h42; // x
			8'h21: keyCode = 7'h52; // c
			8'h2A: keyCode = 7'h63; // v
			8'h32: keyCode = 7'h64; // b
			8'h31: keyCode = 7'h55; // n
			8'h3A: keyCode = 7'h65; // m
			8'h41: keyCode = 7'h66; // comma
			8'h49: keyCode = 7'h67; // full stop
			8'h4A: keyCode = 7'h68; // slash
			8'h59: keyCode = 7'h00; // right shift, same key as left
			8'h11: keyCode = 7'h50; // alt as shift lock
			8'h29: keyCode = 7'h62; // space
			8'h58: keyCode = 7'h40; // caps lock
			8'h05: keyCode = 7'h71; // f1
			8'h06: keyCode = 7'h72; // f2
			8'h04: keyCode = 7'h73; // f3
			8'h0C: keyCode = 7'h14; // f4
			8'h03: keyCode = 7'h74; // f5
			8'h0B: keyCode = 7'h75; // f6
			8'h83: keyCode = 7'h16; // f7
			8'h0A: keyCode = 7'h76; // f8
			8'h01: keyCode = 7'h77; // f9
			8'h09: keyCode = 7'h20; // f10 as f0
			8'h75: keyCode = 7'h39; // up, unprefixed code
			8'h6B: keyCode = 7'h19; // left
			8'h74: keyCode = 7'h79; // right
			8'h72: keyCode = 7'h29; // down
			8'h78: keyCode = 7'h7E; // f11 as BREAK
			8'h07: keyCode = 7'h69; // f12 as copy
			default: keyValid = 1'b0; // also covers F0 and E0
		endcase
	end

endmodule

`default_nettype wire

/* src/ps2Receiver.sv */
`timescale 1ns/100ps
`default_nettype none
`include "keyboard_macros.svh"

module ps2Receiver (
	input  wire                     CLK,
	input  wire                     CLK_en,
	input  wire                     nRESET,
	input  wire                     ps2Clk,
	input  wire                     ps2Data,
	output keyboard_pkg::scanCode_t rxByte,
	output logic                    rxDone
);

	localparam int TickWidth = $clog2(`KB_RX_TIMEOUT);

	logic [1:0] clkSync;
	logic [1:0] dataSync;
	logic clkLast;
	logic fallEdge;
	logic frameOk;
	logic [2:0] bitCount;
	logic parityAcc;
	logic [TickWidth-1:0] idleTicks;
	keyboard_pkg::rxState_t state;
	keyboard_pkg::scanCode_t shiftReg;
	keyboard_pkg::scanCode_t heldByte;

	// two-stage synchronizer, lines idle high
	always_ff @(posedge CLK) begin
		if (!nRESET) begin
			clkSync <= 2'b11;
			dataSync <= 2'b11;
			clkLast <= 1'b1;
		end else if (CLK_en) begin
			clkSync <= {clkSync[0], ps2Clk};
			dataSync <= {dataSync[0], ps2Data};
			clkLast <= clkSync[1];
		end
	end

	assign fallEdge = CLK_en & clkLast & ~clkSync[1];
	assign frameOk = (state == keyboard_pkg::rxStop) & dataSync[1] & parityAcc; // stop high, odd parity
	assign rxDone = fallEdge & frameOk;
	assign rxByte = rxDone ? shiftReg : heldByte; // new byte visible in the done cycle

	always_ff @(posedge CLK) begin
		if (!nRESET) begin
			state <= keyboard_pkg::rxIdle;
			bitCount <= '0;
			parityAcc <= 1'b0;
			idleTicks <= '0;
		end else if (fallEdge) begin
			idleTicks <= '0;
			case (state)
				keyboard_pkg::rxIdle: begin
					if (!dataSync[1]) begin // start bit
						state <= keyboard_pkg::rxData;
						bitCount <= '0;
						parityAcc <= 1'b0;
					end
				end
				keyboard_pkg::rxData: begin
					parityAcc <= parityAcc ^ dataSync[1];
					bitCount <= bitCount + 3'd1;
					if (bitCount == 3'd7)
						state <= keyboard_pkg::rxParity;
				end
				keyboard_pkg::rxParity: begin
					parityAcc <= parityAcc ^ dataSync[1];
					state <= keyboard_pkg::rxStop;
				end
				default: state <= keyboard_pkg::rxIdle; // stop bit taken, good or bad
			endcase
		end else if (CLK_en) begin
			if (state == keyboard_pkg::rxIdle) begin
				idleTicks <= '0;
			end else if (idleTicks == TickWidth'(`KB_RX_TIMEOUT - 1)) begin
				state <= keyboard_pkg::rxIdle; // line went quiet mid-frame
				idleTicks <= '0;
			end else begin
				idleTicks <= idleTicks + 1'b1;
			end
		end
	end

	always_ff @(posedge CLK) begin
		if (fallEdge && state == keyboard_pkg::rxData)
			shiftReg <= {dataSync[1], shiftReg[7:1]}; // LSB arrives first
		if (rxDone)
			heldByte <= shiftReg;
	end

endmodule

`default_nettype wire

/* src/keyboard_pkg.sv */
`default_nettype none

package keyboard_pkg;

	// one byte off the PS/2 line
	typedef logic [7:0] scanCode_t;

	// matrix key code: row in [6:4], column in [3:0]
	typedef logic [6:0] keyCode_t;

	typedef logic [3:0] column_t;

	typedef logic [2:0] row_t;

	// pressed keys of one column, one bit per row
	typedef logic [7:0] rowBits_t;

	// receiver frame position
	typedef enum logic [1:0] {
		rxIdle,   // waiting for a start bit
		rxData,   // eight data bits, LSB first
		rxParity, // odd parity bit
		rxStop    // stop bit, must be 1
	} rxState_t;

endpackage

`default_nettype wire

/* include/keyboard_macros.svh */
`ifndef KEYBOARD_MACROS_SVH
`define KEYBOARD_MACROS_SVH

// matrix geometry
`define KB_COLUMNS 16

// set-2 prefix sent before the code of a released key
`define KB_RELEASE_CODE 8'hF0

// BREAK sits outside the normal scan, on its own output
`define KB_BREAK_COLUMN 14
`define KB_BREAK_ROW 7

// CLK_en ticks without a ps2Clk edge before a partial frame is dropped
`define KB_RX_TIMEOUT 64

`endif
